// ==== include/usb_defs.svh ====
`ifndef USB_DEFS_SVH
`define USB_DEFS_SVH

// Fixed device identity since there is no enumeration
`define USB_DEV_ADDR 7'd5
`define USB_OUT_EP 4'd1

// Largest bulk payload in bytes (full speed)
`define USB_MAX_PACKET 64

// Packet FIFO size in bytes, room for two full packets
`define USB_FIFO_DEPTH 128

// Length of the PHY reset pulse in ulpi_clk cycles
`define PHY_RESET_CYCLES 16

`endif

// ==== logic/usb_pkg.sv ====
package usb_pkg;

  // 4-bit PID, the wire byte is {~pid, pid}
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010
  } usb_pid_e;

  typedef struct packed {
    logic [4:0] crc5;
    logic [3:0] endp;
    logic [6:0] addr;   // First on the wire
  } usb_token_t;

  typedef struct packed {
    logic [4:0]  crc5;
    logic [10:0] frame;
  } usb_sof_t;

  // Two body bytes after the PID, first byte in [7:0]
  typedef union packed {
    usb_token_t token;
    usb_sof_t   sof;
  } usb_token_u;

  // CRCs are kept bit-reversed so bytes feed in LSB first;
  // the sent CRC is the inverted register, low bits first
  localparam logic [4:0]  CRC5_INIT      = 5'h1f;
  localparam logic [4:0]  CRC5_RESIDUE   = 5'h06;
  localparam logic [15:0] CRC16_INIT     = 16'hffff;
  localparam logic [15:0] CRC16_RESIDUE  = 16'hb001;

  // Token CRC, nbits allows the 3-bit tail of an 11-bit field
  function automatic logic [4:0] crc5_step(input logic [4:0] crc, input logic [7:0] data,
                                           input int unsigned nbits = 8);
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (i < nbits) begin
        if (c[0] ^ data[i])
          c = (c >> 1) ^ 5'h14;   // x^5 + x^2 + 1 reflected
        else
          c = c >> 1;
      end
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i])
        c = (c >> 1) ^ 16'ha001;  // x^16 + x^15 + x^2 + 1 reflected
      else
        c = c >> 1;
    end
    return c;
  endfunction

endpackage

// ==== logic/ulpi_reset.sv ====
`include "usb_defs.svh"

module ulpi_reset (
  input  logic ulpi_clk,
  input  logic reset_i,
  input  logic ulpi_dir_i,
  output logic ulpi_rst_o,
  output logic link_reset_o
);

  localparam int CW = $clog2(`PHY_RESET_CYCLES);

  typedef enum logic [1:0] {ST_PHY_RST, ST_WAIT_DIR, ST_RUN} state_e;

  state_e        state;
  logic [CW-1:0] count;

  always_ff @(posedge ulpi_clk) begin
    if (reset_i) begin
      state        <= ST_PHY_RST;
      count        <= '0;
      ulpi_rst_o   <= 1'b1;
      link_reset_o <= 1'b1;
    end else begin
      case (state)
        ST_PHY_RST: begin
          count <= count + 1'b1;
          if (count == CW'(`PHY_RESET_CYCLES - 1)) begin
            ulpi_rst_o <= 1'b0;
            state      <= ST_WAIT_DIR;
          end
        end
        // PHY holds dir high until its clock is stable
        ST_WAIT_DIR: begin
          if (!ulpi_dir_i) begin
            link_reset_o <= 1'b0;
            state        <= ST_RUN;
          end
        end
        default: ;  // Running, stay here until reset_i
      endcase
    end
  end

  a_link_after_phy: assert property (@(posedge ulpi_clk) disable iff (reset_i)
    $fell(link_reset_o) |-> !$past(ulpi_rst_o))
    else $error("Link reset released while PHY reset still active");

endmodule

// ==== logic/ulpi_link.sv ====
module ulpi_link (
  input  logic              ulpi_clk,
  input  logic              reset_i,
  input  logic              ulpi_dir_i,
  input  logic              ulpi_nxt_i,
  output logic              ulpi_stp_o,
  inout  wire  [7:0]        ulpi_data_io,
  output logic              rx_valid_o,
  output logic [7:0]        rx_data_o,
  output logic              rx_active_o,
  input  logic              hs_valid_i,
  input  usb_pkg::usb_pid_e hs_pid_i,
  output logic              hs_ready_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_CMD, TX_STP} tx_state_e;

  tx_state_e  tx_state;
  logic       dir_q;
  logic       tx_en;
  logic [7:0] tx_data;
  logic       rx_cycle;
  logic       bus_free;

  assign rx_cycle = ulpi_dir_i && dir_q;     // PHY drives, not a turnaround
  assign bus_free = !ulpi_dir_i && !dir_q;

  // Released at once when the PHY takes the bus
  assign ulpi_data_io = (tx_en && !ulpi_dir_i) ? tx_data : 8'hzz;

  assign hs_ready_o = (tx_state == TX_IDLE) && hs_valid_i && bus_free;

  // Receive side
  always_ff @(posedge ulpi_clk) begin
    if (reset_i) begin
      dir_q       <= 1'b0;
      rx_valid_o  <= 1'b0;
      rx_active_o <= 1'b0;
    end else begin
      dir_q      <= ulpi_dir_i;
      rx_valid_o <= rx_cycle && ulpi_nxt_i;
      if (!ulpi_dir_i)
        rx_active_o <= 1'b0;
      else if (!dir_q && ulpi_nxt_i)
        rx_active_o <= 1'b1;                 // Turnaround with nxt starts a packet
      else if (rx_cycle && !ulpi_nxt_i)
        rx_active_o <= ulpi_data_io[4];      // RX CMD RxActive
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (rx_cycle)
      rx_data_o <= ulpi_data_io;
  end

  // Handshake transmit, TX CMD then stp
  always_ff @(posedge ulpi_clk) begin
    if (reset_i) begin
      tx_state   <= TX_IDLE;
      tx_en      <= 1'b0;
      ulpi_stp_o <= 1'b0;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          if (hs_ready_o) begin
            tx_en    <= 1'b1;
            tx_state <= TX_CMD;
          end
        end
        TX_CMD: begin
          if (ulpi_dir_i) begin
            tx_en    <= 1'b0;                // Lost the bus, drop it
            tx_state <= TX_IDLE;
          end else if (ulpi_nxt_i) begin
            ulpi_stp_o <= 1'b1;
            tx_state   <= TX_STP;
          end
        end
        default: begin
          ulpi_stp_o <= 1'b0;
          tx_en      <= 1'b0;
          tx_state   <= TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (hs_ready_o)
      tx_data <= {4'h4, hs_pid_i};           // Transmit with PID
    else if (tx_state == TX_CMD && ulpi_nxt_i)
      tx_data <= 8'h00;                      // Idle data with stp
  end

  a_no_drive_on_rx: assert property (@(posedge ulpi_clk) disable iff (reset_i)
    rx_cycle |-> !tx_en)
    else $error("Link still driving ulpi_data_io after PHY took the bus");

endmodule

// ==== logic/usb_packet_decoder.sv ====
module usb_packet_decoder (
  input  logic                ulpi_clk,
  input  logic                reset_i,
  input  logic                rx_valid_i,
  input  logic [7:0]          rx_data_i,
  input  logic                rx_active_i,
  output logic                tok_valid_o,
  output usb_pkg::usb_pid_e   tok_pid_o,
  output usb_pkg::usb_token_u tok_body_o,
  output logic                dat_valid_o,
  output logic [7:0]          dat_data_o,
  output logic                pkt_end_o,
  output logic                pkt_ok_o,
  output usb_pkg::usb_pid_e   pkt_pid_o,
  output logic                crc_error_o
);

  import usb_pkg::*;

  typedef enum logic [1:0] {ST_PID, ST_TOKEN, ST_DATA, ST_SKIP} state_e;

  state_e      state;
  logic        active_q;
  logic        pkt_done;
  logic        pid_good;
  usb_pid_e    pid_q;
  logic [1:0]  byte_cnt;     // Token body bytes or held data bytes
  logic        token_long;
  usb_token_u  body_q;
  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  logic [7:0]  hold0;
  logic [7:0]  hold1;
  logic        tok_good;
  logic        dat_good;

  assign pkt_done = active_q && !rx_active_i;
  assign pid_good = (rx_data_i[7:4] == ~rx_data_i[3:0]);
  assign tok_good = (byte_cnt == 2'd2) && !token_long && (crc5_q == CRC5_RESIDUE);
  assign dat_good = (byte_cnt == 2'd2) && (crc16_q == CRC16_RESIDUE);

  always_ff @(posedge ulpi_clk) begin
    if (reset_i) begin
      state       <= ST_PID;
      active_q    <= 1'b0;
      tok_valid_o <= 1'b0;
      dat_valid_o <= 1'b0;
      pkt_end_o   <= 1'b0;
      crc_error_o <= 1'b0;
    end else begin
      active_q    <= rx_active_i;
      tok_valid_o <= 1'b0;
      dat_valid_o <= 1'b0;
      pkt_end_o   <= 1'b0;
      crc_error_o <= 1'b0;
      case (state)
        ST_PID: begin
          if (rx_valid_i) begin
            if (!pid_good) begin
              crc_error_o <= 1'b1;
              state       <= ST_SKIP;
            end else if (rx_data_i[1:0] == 2'b01) begin
              state <= ST_TOKEN;
            end else if (rx_data_i[1:0] == 2'b11) begin
              state <= ST_DATA;
            end else begin
              state <= ST_SKIP;      // Handshakes from the host are ignored
            end
          end
        end
        ST_TOKEN: begin
          if (pkt_done) begin
            crc_error_o <= !tok_good;
            tok_valid_o <= tok_good && (pid_q != PID_SOF);
            state       <= ST_PID;
          end
        end
        ST_DATA: begin
          if (pkt_done) begin
            pkt_end_o   <= 1'b1;
            crc_error_o <= !dat_good;
            state       <= ST_PID;
          end else if (rx_valid_i && byte_cnt == 2'd2) begin
            dat_valid_o <= 1'b1;     // Oldest held byte is payload
          end
        end
        default: begin
          if (pkt_done)
            state <= ST_PID;
        end
      endcase
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (state == ST_PID && rx_valid_i) begin
      pid_q      <= usb_pid_e'(rx_data_i[3:0]);
      byte_cnt   <= 2'd0;
      token_long <= 1'b0;
      crc5_q     <= CRC5_INIT;
      crc16_q    <= CRC16_INIT;
    end else if (rx_valid_i) begin
      crc5_q     <= crc5_step(crc5_q, rx_data_i);
      crc16_q    <= crc16_step(crc16_q, rx_data_i);
      body_q     <= {rx_data_i, body_q[15:8]};
      hold1      <= hold0;
      hold0      <= rx_data_i;
      dat_data_o <= hold1;
      if (byte_cnt == 2'd2)
        token_long <= 1'b1;
      else
        byte_cnt <= byte_cnt + 1'b1;
    end
    if (pkt_done) begin
      tok_pid_o  <= pid_q;
      tok_body_o <= body_q;
      pkt_pid_o  <= pid_q;
      pkt_ok_o   <= dat_good;
    end
  end

endmodule

// ==== logic/usb_out_endpoint.sv ====
`include "usb_defs.svh"

module usb_out_endpoint (
  input  logic                ulpi_clk,
  input  logic                reset_i,
  input  logic                tok_valid_i,
  input  usb_pkg::usb_pid_e   tok_pid_i,
  input  usb_pkg::usb_token_u tok_body_i,
  input  logic                dat_valid_i,
  input  logic [7:0]          dat_data_i,
  input  logic                pkt_end_i,
  input  logic                pkt_ok_i,
  input  usb_pkg::usb_pid_e   pkt_pid_i,
  input  logic                hs_ready_i,
  output logic                hs_valid_o,
  output usb_pkg::usb_pid_e   hs_pid_o,
  output logic                blko_tvalid_o,
  input  logic                blko_tready_i,
  output logic                blko_tlast_o,
  output logic [7:0]          blko_tdata_o
);

  import usb_pkg::*;

  localparam int AW = $clog2(`USB_FIFO_DEPTH);
  localparam int PW = AW + 1;
  localparam int LW = $clog2(`USB_MAX_PACKET + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_RECV, ST_DISCARD, ST_HS} state_e;

  state_e        state;
  logic          toggle;     // Expected DATA PID, 0 is DATA0
  logic [PW-1:0] wr_ptr;     // Tentative, rolls back on drop
  logic [PW-1:0] cmt_ptr;
  logic [PW-1:0] rd_ptr;
  logic [LW-1:0] rx_len;
  logic          overrun;
  logic          pend_v;
  logic [7:0]    pend_data;  // Last byte waits to learn its tlast
  logic [8:0]    fifo_mem [`USB_FIFO_DEPTH];
  logic [PW:0]   free_w;
  logic          our_out;
  logic          seq_ok;
  logic          commit;
  logic          wr_en;

  assign our_out = tok_valid_i && (tok_pid_i == PID_OUT) &&
                   (tok_body_i.token.addr == `USB_DEV_ADDR) &&
                   (tok_body_i.token.endp == `USB_OUT_EP);
  assign free_w  = (PW+1)'(`USB_FIFO_DEPTH) - {1'b0, cmt_ptr - rd_ptr};
  assign seq_ok  = (pkt_pid_i == (toggle ? PID_DATA1 : PID_DATA0));
  assign commit  = (state == ST_RECV) && pkt_end_i && pkt_ok_i && !overrun && seq_ok;
  assign wr_en   = (state == ST_RECV) && pend_v &&
                   ((dat_valid_i && rx_len != LW'(`USB_MAX_PACKET)) || commit);

  assign hs_valid_o    = (state == ST_HS);
  assign blko_tvalid_o = (rd_ptr != cmt_ptr);
  assign {blko_tlast_o, blko_tdata_o} = fifo_mem[rd_ptr[AW-1:0]];

  always_ff @(posedge ulpi_clk) begin
    if (reset_i) begin
      state    <= ST_IDLE;
      toggle   <= 1'b0;
      wr_ptr   <= '0;
      cmt_ptr  <= '0;
      rd_ptr   <= '0;
      rx_len   <= '0;
      overrun  <= 1'b0;
      pend_v   <= 1'b0;
      hs_pid_o <= PID_ACK;
    end else begin
      if (blko_tvalid_o && blko_tready_i)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (state != ST_HS && our_out) begin
        wr_ptr  <= cmt_ptr;
        rx_len  <= '0;
        overrun <= 1'b0;
        pend_v  <= 1'b0;
        // Room for a full packet or NAK it
        state <= (free_w >= (PW+1)'(`USB_MAX_PACKET)) ? ST_RECV : ST_DISCARD;
      end else if (state != ST_HS && tok_valid_i) begin
        state <= ST_IDLE;    // Not for this endpoint
      end else begin
        case (state)
          ST_RECV: begin
            if (pkt_end_i) begin
              if (pkt_ok_i && !overrun) begin
                hs_pid_o <= PID_ACK;
                state    <= ST_HS;
                if (seq_ok) begin
                  toggle  <= !toggle;
                  cmt_ptr <= wr_ptr + PW'(pend_v);
                end else begin
                  wr_ptr <= cmt_ptr;   // Host missed our ACK, data is a repeat
                end
              end else begin
                wr_ptr <= cmt_ptr;
                state  <= ST_IDLE;
              end
            end else if (dat_valid_i) begin
              if (rx_len == LW'(`USB_MAX_PACKET)) begin
                overrun <= 1'b1;
              end else begin
                rx_len <= rx_len + 1'b1;
                pend_v <= 1'b1;
              end
            end
          end
          ST_DISCARD: begin
            if (pkt_end_i && pkt_ok_i) begin
              hs_pid_o <= PID_NAK;
              state    <= ST_HS;
            end else if (pkt_end_i) begin
              state <= ST_IDLE;
            end
          end
          ST_HS: begin
            if (hs_ready_i)
              state <= ST_IDLE;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (dat_valid_i)
      pend_data <= dat_data_i;
    if (wr_en)
      fifo_mem[wr_ptr[AW-1:0]] <= {commit, pend_data};
  end

  a_fifo_no_overflow: assert property (@(posedge ulpi_clk) disable iff (reset_i)
    wr_en |-> (wr_ptr - rd_ptr) < PW'(`USB_FIFO_DEPTH))
    else $error("Packet FIFO overflow");

endmodule

// ==== logic/usb_ulpi_core.sv ====
module usb_ulpi_core (
  input  logic       ulpi_clk,
  input  logic       reset_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic       ulpi_stp_o,
  output logic       ulpi_rst_o,
  inout  wire  [7:0] ulpi_data_io,
  output logic       usb_reset_o,
  output logic       crc_error_o,
  output logic       blko_tvalid_o,
  input  logic       blko_tready_i,
  output logic       blko_tlast_o,
  output logic [7:0] blko_tdata_o
);

  import usb_pkg::*;

  logic       rx_valid;
  logic [7:0] rx_data;
  logic       rx_active;
  logic       tok_valid;
  usb_pid_e   tok_pid;
  usb_token_u tok_body;
  logic       dat_valid;
  logic [7:0] dat_data;
  logic       pkt_end;
  logic       pkt_ok;
  usb_pid_e   pkt_pid;
  logic       hs_valid;
  logic       hs_ready;
  usb_pid_e   hs_pid;

  // PHY reset, usb_reset_o holds everything else until the PHY is up
  ulpi_reset u_reset (
    .ulpi_clk    (ulpi_clk),
    .reset_i     (reset_i),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_rst_o  (ulpi_rst_o),
    .link_reset_o(usb_reset_o)
  );

  ulpi_link u_link (
    .ulpi_clk    (ulpi_clk),
    .reset_i     (usb_reset_o),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_stp_o  (ulpi_stp_o),
    .ulpi_data_io(ulpi_data_io),
    .rx_valid_o  (rx_valid),
    .rx_data_o   (rx_data),
    .rx_active_o (rx_active),
    .hs_valid_i  (hs_valid),
    .hs_pid_i    (hs_pid),
    .hs_ready_o  (hs_ready)
  );

  usb_packet_decoder u_decode (
    .ulpi_clk   (ulpi_clk),
    .reset_i    (usb_reset_o),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_active_i(rx_active),
    .tok_valid_o(tok_valid),
    .tok_pid_o  (tok_pid),
    .tok_body_o (tok_body),
    .dat_valid_o(dat_valid),
    .dat_data_o (dat_data),
    .pkt_end_o  (pkt_end),
    .pkt_ok_o   (pkt_ok),
    .pkt_pid_o  (pkt_pid),
    .crc_error_o(crc_error_o)
  );

  usb_out_endpoint u_ep_out (
    .ulpi_clk     (ulpi_clk),
    .reset_i      (usb_reset_o),
    .tok_valid_i  (tok_valid),
    .tok_pid_i    (tok_pid),
    .tok_body_i   (tok_body),
    .dat_valid_i  (dat_valid),
    .dat_data_i   (dat_data),
    .pkt_end_i    (pkt_end),
    .pkt_ok_i     (pkt_ok),
    .pkt_pid_i    (pkt_pid),
    .hs_ready_i   (hs_ready),
    .hs_valid_o   (hs_valid),
    .hs_pid_o     (hs_pid),
    .blko_tvalid_o(blko_tvalid_o),  // Bulk OUT stream
    .blko_tready_i(blko_tready_i),
    .blko_tlast_o (blko_tlast_o),
    .blko_tdata_o (blko_tdata_o)
  );

endmodule

// ==== tests/ulpi_phy_model.sv ====
module ulpi_phy_model (
  input  logic       clk_i,
  input  logic       ulpi_rst_i,
  output logic       dir_o,
  output logic       nxt_o,
  inout  wire  [7:0] data_io
);

  timeunit 1ns;
  timeprecision 1ps;

  import usb_pkg::*;

  typedef logic [7:0] byte_q_t [$];

  logic       dir_q  = 1'b1;  // PHY owns the bus until its startup is over
  logic       nxt_rx = 1'b0;
  logic       nxt_tx = 1'b0;
  logic [7:0] data_q = 8'h00;
  usb_pid_e   tx_pids [$];    // Handshakes sent by the link in arrival order

  assign dir_o   = dir_q;
  assign nxt_o   = nxt_rx | nxt_tx;
  assign data_io = dir_q ? data_q : 8'hzz;

  function automatic logic [7:0] pid_byte(input usb_pid_e pid);
    return {~4'(pid), 4'(pid)};
  endfunction

  // The bus stays with the PHY while its reset input is high
  task automatic release_bus();
    @(posedge clk_i);
    #1 dir_q = ulpi_rst_i;
  endtask

  // One received packet as a turnaround with nxt and then a byte per cycle
  task automatic send_bytes(input byte_q_t bytes);
    repeat (3) @(posedge clk_i);   // Let a finished TX CMD free the bus
    #1;
    dir_q  = 1'b1;
    nxt_rx = 1'b1;
    data_q = 8'h00;
    foreach (bytes[i]) begin
      @(posedge clk_i);
      #1 data_q = bytes[i];
    end
    @(posedge clk_i);
    #1;
    dir_q  = 1'b0;                 // End of packet
    nxt_rx = 1'b0;
  endtask

  task automatic send_token(input usb_pid_e pid, input logic [6:0] addr,
                            input logic [3:0] endp);
    usb_token_u tok;
    logic [4:0] crc;
    byte_q_t    bytes;
    tok.token.addr = addr;
    tok.token.endp = endp;
    crc = crc5_step(CRC5_INIT, tok[7:0]);
    crc = crc5_step(crc, {5'b0, tok[10:8]}, 3);   // 11 bits in all
    tok.token.crc5 = ~crc;
    bytes.push_back(pid_byte(pid));
    bytes.push_back(tok[7:0]);
    bytes.push_back(tok[15:8]);
    send_bytes(bytes);
  endtask

  task automatic send_data(input usb_pid_e pid, input byte_q_t payload, input logic corrupt);
    logic [15:0] crc;
    byte_q_t     bytes;
    crc = CRC16_INIT;
    bytes.push_back(pid_byte(pid));
    foreach (payload[i]) begin
      crc = crc16_step(crc, payload[i]);
      bytes.push_back(payload[i]);
    end
    crc = ~crc;
    if (corrupt)
      crc[3] = !crc[3];            // Single bit error in the sent CRC
    bytes.push_back(crc[7:0]);
    bytes.push_back(crc[15:8]);
    send_bytes(bytes);
  endtask

  // Accept a TX CMD with one nxt cycle and log its PID
  always begin
    @(posedge clk_i);
    if (!dir_q && data_io[7:4] === 4'h4) begin
      tx_pids.push_back(usb_pid_e'(data_io[3:0]));
      #1 nxt_tx = 1'b1;
      @(posedge clk_i);
      #1 nxt_tx = 1'b0;
    end
  end

endmodule

// ==== tests/tb_usb_ulpi_core.sv ====
`include "usb_defs.svh"

module tb_usb_ulpi_core;

  timeunit 1ns;
  timeprecision 1ps;

  import usb_pkg::*;

  typedef logic [7:0] byte_q_t [$];

  localparam int HS_TIMEOUT     = 8;
  localparam int QUIET_CYCLES   = 40;
  localparam int STREAM_TIMEOUT = 400;

  logic       clk;
  logic       reset_i;
  logic       ulpi_dir;
  logic       ulpi_nxt;
  logic       ulpi_stp;
  logic       ulpi_rst;
  wire  [7:0] ulpi_data;
  logic       usb_reset;
  logic       crc_error;
  logic       blko_tvalid;
  logic       blko_tready;
  logic       blko_tlast;
  logic [7:0] blko_tdata;

  logic [8:0] got_q [$];     // Bytes taken from blko with tlast in bit 8
  logic [8:0] exp_q [$];
  int         checked  = 0;  // Stream bytes already compared
  int         pid_rd   = 0;  // Next captured handshake to look at
  int         crc_errs = 0;

  usb_ulpi_core UUT (
    .ulpi_clk     (clk),
    .reset_i      (reset_i),
    .ulpi_dir_i   (ulpi_dir),
    .ulpi_nxt_i   (ulpi_nxt),
    .ulpi_stp_o   (ulpi_stp),
    .ulpi_rst_o   (ulpi_rst),
    .ulpi_data_io (ulpi_data),
    .usb_reset_o  (usb_reset),
    .crc_error_o  (crc_error),
    .blko_tvalid_o(blko_tvalid),
    .blko_tready_i(blko_tready),
    .blko_tlast_o (blko_tlast),
    .blko_tdata_o (blko_tdata)
  );

  ulpi_phy_model phy (
    .clk_i     (clk),
    .ulpi_rst_i(ulpi_rst),
    .dir_o     (ulpi_dir),
    .nxt_o     (ulpi_nxt),
    .data_io   (ulpi_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (blko_tvalid && blko_tready)
      got_q.push_back({blko_tlast, blko_tdata});
    if (crc_error)
      crc_errs++;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp)
      else report_error($sformatf("ERROR %s: expected %0h, actual %0h", name, exp, act));
  endtask

  function automatic byte_q_t random_payload(input int len);
    byte_q_t pay;
    for (int i = 0; i < len; i++)
      pay.push_back(8'($urandom));
    return pay;
  endfunction

  // Expected blko bytes with tlast only on the last one
  task automatic queue_packet(input byte_q_t pay);
    foreach (pay[i])
      exp_q.push_back({i == pay.size() - 1, pay[i]});
  endtask

  task automatic send_out(input logic [6:0] addr, input logic [3:0] endp, input usb_pid_e pid,
                          input byte_q_t pay, input logic corrupt);
    phy.send_token(PID_OUT, addr, endp);
    phy.send_data(pid, pay, corrupt);
  endtask

  // The TX CMD must show up within 8 cycles of dir falling
  task automatic expect_handshake(input string name, input usb_pid_e pid);
    int wait_cycles;
    wait_cycles = 0;
    while (phy.tx_pids.size() == pid_rd && wait_cycles < HS_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    assert (phy.tx_pids.size() > pid_rd)
      else report_error($sformatf("%s: no handshake within %0d cycles", name, HS_TIMEOUT));
    check_value(name, 32'(pid), 32'(phy.tx_pids[pid_rd]));
    pid_rd++;
  endtask

  // Neither a handshake nor stream data within the window
  task automatic expect_quiet(input string name);
    repeat (QUIET_CYCLES) @(negedge clk);
    check_value({name, " handshakes"}, pid_rd, phy.tx_pids.size());
    check_value({name, " blko bytes"}, checked, got_q.size());
  endtask

  task automatic check_stream(input string name);
    int wait_cycles;
    wait_cycles = 0;
    while (got_q.size() < exp_q.size() && wait_cycles < STREAM_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    assert (got_q.size() >= exp_q.size())
      else report_error($sformatf("%s: blko gave %0d of %0d bytes before the timeout",
                                  name, got_q.size(), exp_q.size()));
    for (int i = checked; i < exp_q.size(); i++)
      check_value($sformatf("%s byte %0d", name, i), 32'(exp_q[i]), 32'(got_q[i]));
    checked = exp_q.size();
    repeat (8) @(negedge clk);
    check_value({name, " byte count"}, exp_q.size(), got_q.size());
  endtask

  task automatic reset_sequence();
    int wait_cycles;
    repeat (2) @(posedge clk);
    #1 reset_i = 1'b0;
    @(negedge clk);
    check_value("reset ulpi_rst_o", 1, 32'(ulpi_rst));
    wait_cycles = 0;
    while (ulpi_rst && wait_cycles < 40) begin
      check_value("reset stp", 0, 32'(ulpi_stp));
      check_value("reset blko_tvalid", 0, 32'(blko_tvalid));
      check_value("reset crc_error", 0, 32'(crc_error));
      @(negedge clk);
      wait_cycles++;
    end
    assert (!ulpi_rst) else report_error("ulpi_rst_o never fell after the PHY reset time");
    phy.release_bus();
    wait_cycles = 0;
    while (usb_reset && wait_cycles < 10) begin
      check_value("reset stp", 0, 32'(ulpi_stp));
      check_value("reset blko_tvalid", 0, 32'(blko_tvalid));
      @(negedge clk);
      wait_cycles++;
    end
    assert (!usb_reset) else report_error("usb_reset_o stayed high after the PHY freed the bus");
    check_value("reset stp", 0, 32'(ulpi_stp));
    check_value("reset blko_tvalid", 0, 32'(blko_tvalid));
    check_value("reset crc_error", 0, 32'(crc_error));
    check_value("reset handshakes", 0, phy.tx_pids.size());
  endtask

  task automatic good_out();
    byte_q_t pay;
    pay = random_payload(16);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA0, pay, 1'b0);
    expect_handshake("good_out", PID_ACK);
    queue_packet(pay);
    check_stream("good_out");
  endtask

  task automatic bad_crc_retry();
    byte_q_t pay;
    int      errs_before;
    pay = random_payload(24);
    errs_before = crc_errs;
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay, 1'b1);
    expect_quiet("bad_crc");
    assert (crc_errs > errs_before)
      else report_error("bad_crc: crc_error_o did not pulse for a corrupted CRC16");
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay, 1'b0);
    expect_handshake("bad_crc retry", PID_ACK);
    queue_packet(pay);
    check_stream("bad_crc retry");
  endtask

  task automatic wrong_target();
    byte_q_t pay;
    pay = random_payload(8);
    send_out(`USB_DEV_ADDR + 7'd1, `USB_OUT_EP, PID_DATA0, pay, 1'b0);
    expect_quiet("wrong_address");
    send_out(`USB_DEV_ADDR, `USB_OUT_EP + 4'd1, PID_DATA0, pay, 1'b0);
    expect_quiet("wrong_endpoint");
  endtask

  // Host missed an ACK and repeats DATA1
  task automatic repeated_data1();
    byte_q_t pay0;
    byte_q_t pay1;
    byte_q_t pay2;
    pay0 = random_payload(5);
    pay1 = random_payload(12);
    pay2 = random_payload(3);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA0, pay0, 1'b0);
    expect_handshake("repeat first", PID_ACK);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay1, 1'b0);
    expect_handshake("repeat data1", PID_ACK);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay1, 1'b0);
    expect_handshake("repeat data1 again", PID_ACK);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA0, pay2, 1'b0);
    expect_handshake("repeat next data0", PID_ACK);
    queue_packet(pay0);
    queue_packet(pay1);
    queue_packet(pay2);
    check_stream("repeat_data1");
  endtask

  task automatic backpressure();
    byte_q_t pay_a;
    byte_q_t pay_b;
    byte_q_t pay_c;
    pay_a = random_payload(`USB_MAX_PACKET);
    pay_b = random_payload(`USB_MAX_PACKET);
    pay_c = random_payload(`USB_MAX_PACKET);
    @(posedge clk);
    #1 blko_tready = 1'b0;
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay_a, 1'b0);
    expect_handshake("backpressure first", PID_ACK);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA0, pay_b, 1'b0);
    expect_handshake("backpressure second", PID_ACK);
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay_c, 1'b0);
    expect_handshake("backpressure full", PID_NAK);
    // First byte of the first packet waits on blko
    check_value("backpressure tvalid", 1, 32'(blko_tvalid));
    check_value("backpressure held byte", 32'({1'b0, pay_a[0]}),
                32'({blko_tlast, blko_tdata}));
    queue_packet(pay_a);
    queue_packet(pay_b);
    @(posedge clk);
    #1 blko_tready = 1'b1;
    check_stream("backpressure drain");
    send_out(`USB_DEV_ADDR, `USB_OUT_EP, PID_DATA1, pay_c, 1'b0);
    expect_handshake("backpressure resend", PID_ACK);
    queue_packet(pay_c);
    check_stream("backpressure resend");
  endtask

  initial begin
    reset_i     = 1'b1;
    blko_tready = 1'b1;
    void'($urandom(56964));
    reset_sequence();
    good_out();
    bad_crc_retry();
    wrong_target();
    repeated_data1();
    backpressure();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== usb_ulpi_core.f ====
+incdir+include
logic/usb_pkg.sv
logic/ulpi_reset.sv
logic/ulpi_link.sv
logic/usb_packet_decoder.sv
logic/usb_out_endpoint.sv
logic/usb_ulpi_core.sv
tests/ulpi_phy_model.sv
tests/tb_usb_ulpi_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_usb_ulpi_core
FILELIST  ?= usb_ulpi_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
